/* compile.f */
+incdir+hw
+incdir+tests
hw/cachePkg.sv
hw/cacheWayRam.sv
hw/cacheCtrl.sv
hw/cacheRefill.sv
hw/cacheTop.sv
tests/cacheTb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= cacheTb
RTL_TOP    ?= cacheTop
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= -Wall
RTL_SRCS   ?= hw/cachePkg.sv hw/cacheWayRam.sv hw/cacheCtrl.sv hw/cacheRefill.sv hw/cacheTop.sv
SOURCES    := $(wildcard hw/*.sv hw/*.svh tests/*.sv tests/*.svh)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# exit status of the simulation binary carries pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) +incdir+hw $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* tests/cacheTbTasks.svh */
// model lookup in request order returning 1 on a predicted hit
function automatic logic lookup(input logic [`ADDR_W-1:0] a);
  logic [`TAG_W-1:0] tag;
  int idx;
  int way;
  tag = a[`ADDR_W-1 -: `TAG_W];
  idx = int'(a[`OFFSET_W +: `INDEX_W]);
  for (way = 0; way < 2; way++) begin
    if (modelValid[way][idx] && modelTag[way][idx] == tag) begin
      modelLru[idx] = (way == 0);
      return 1'b1;
    end
  end
  // invalid way first and otherwise the lru way
  way = !modelValid[0][idx] ? 0 : !modelValid[1][idx] ? 1 : int'(modelLru[idx]);
  modelValid[way][idx] = 1'b1;
  modelTag[way][idx]   = tag;
  modelLru[idx]        = (way == 0);
  modelReads           = modelReads + 1;
  return 1'b0;
endfunction

task automatic clearModel(input logic withLru);
  for (int s = 0; s < `SETS; s++) begin
    modelValid[0][s] = 1'b0;
    modelValid[1][s] = 1'b0;
    if (withLru) begin
      modelLru[s] = 1'b0;
    end
  end
endtask

// returns at the falling edge before the accepting edge
task automatic issue(input logic [`ADDR_W-1:0] a);
  pending_t p;
  int t;
  @(negedge clk);
  valid = 1'b1;
  addr  = a;
  t = 0;
  while (!addrOk) begin
    @(negedge clk);
    t++;
    assert (t < TIMEOUT) else failRun("timeout waiting for addrOk_o");
  end
  p.addr    = a;
  p.hit     = lookup(a);
  p.accEdge = edgeCnt + 1;
  pendQ.push_back(p);
endtask

task automatic releaseBus();
  @(negedge clk);
  valid = 1'b0;
endtask

task automatic drain();
  int t;
  t = 0;
  while (pendQ.size() > 0) begin
    @(negedge clk);
    t++;
    assert (t < TIMEOUT) else failRun("timeout waiting for dataOk_o");
  end
endtask

task automatic checkReads(input int expected);
  assert (lineReads == expected && modelReads == expected) else
    failRun($sformatf("FAIL lineReads: got %h expected %h model %h",
                      lineReads, expected, modelReads));
endtask

task automatic readOne(input logic [`ADDR_W-1:0] a, input int reads);
  issue(a);
  releaseBus();
  drain();
  checkReads(reads);
endtask

task automatic resetState();
  for (int n = 0; n < 4; n++) begin
    @(negedge clk);
    assert (addrOk && !dataOk && !cacheRdValid) else
      failRun($sformatf("FAIL addrOk_o dataOk_o cacheRdValid_o: got %h %h %h expected 1 0 0",
                        addrOk, dataOk, cacheRdValid));
  end
endtask

task automatic coldMissRead();
  int t;
  issue(32'h0000_1048);
  releaseBus();
  t = 0;
  while (!cacheRdValid) begin
    @(negedge clk);
    t++;
    assert (t < TIMEOUT) else failRun("timeout waiting for cacheRdValid_o");
  end
  assert (memAddr == 32'h0000_1040) else
    failRun($sformatf("FAIL memAddr_o: got %h expected %h", memAddr, 32'h0000_1040));
  drain();
  checkReads(1);
endtask

// same line and then four hits back to back
task automatic sameLineHits();
  readOne(32'h0000_1050, 1);
  for (int w = 0; w < `BEATS; w++) begin
    issue(32'h0000_1040 + `ADDR_W'(w * 8));
  end
  releaseBus();
  drain();
  checkReads(1);
endtask

// tags 5, 6 and 7 all in set 9
task automatic setEviction();
  readOne(32'h0000_2920, 2);
  readOne(32'h0000_3128, 3);
  readOne(32'h0000_2938, 3);
  readOne(32'h0000_3920, 4);
  readOne(32'h0000_2928, 4);
  readOne(32'h0000_3130, 5);
endtask

task automatic flushInvalidates();
  @(negedge clk);
  flush = 1'b1;
  @(negedge clk);
  flush = 1'b0;
  clearModel(1'b0);
  readOne(32'h0000_2920, 6);
  readOne(32'h0000_1048, 7);
endtask

// four tags over two sets and four words
task automatic randomReads();
  logic [`ADDR_W-1:0] r;
  for (int n = 0; n < 200; n++) begin
    r = $random(seed);
    issue(32'h0004_0000 | (r & 32'h0000_1838));
  end
  releaseBus();
  drain();
  checkReads(modelReads);
endtask

/* tests/cacheTb.sv */
`include "cache_macros.svh"

module cacheTb;

  localparam int TIMEOUT = 400;

  // one accepted request awaiting its response
  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
    logic               hit;
    int                 accEdge;
  } pending_t;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               valid;
  logic [`ADDR_W-1:0] addr;
  logic               flush;
  logic               addrOk;
  logic               dataOk;
  logic [`XLEN-1:0]   rdData;
  logic               cacheRdValid;
  logic [`ADDR_W-1:0] memAddr;
  // memory side inputs driven by the responder
  logic               rdDataValid = 1'b0;
  logic               rdLast = 1'b0;
  logic [`XLEN-1:0]   memData = '0;

  int edgeCnt = 0;
  int lineReads = 0;
  int modelReads = 0;
  int seed;
  int gapSeed = 32'h2745_e85f;
  int beatNo = 0;
  int gapLeft = 0;
  logic inRead = 1'b0;
  logic [`ADDR_W-1:0] readAddr = '0;
  pending_t pendQ[$];

  // reference model state per way and set
  logic [`TAG_W-1:0] modelTag [2][`SETS];
  logic              modelValid [2][`SETS];
  logic              modelLru [`SETS];

  cacheTop dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid),
    .addr_i         (addr),
    .flush_i        (flush),
    .addrOk_o       (addrOk),
    .dataOk_o       (dataOk),
    .rdData_o       (rdData),
    .cacheRdValid_o (cacheRdValid),
    .memAddr_o      (memAddr),
    .rdDataValid_i  (rdDataValid),
    .rdLast_i       (rdLast),
    .rdData_i       (memData)
  );

  always #50 clk = ~clk;

  always @(posedge clk) edgeCnt <= edgeCnt + 1;

  task automatic failRun(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // beat address on top and its inverse below
  function automatic logic [`XLEN-1:0] memWord(input logic [`ADDR_W-1:0] a);
    return {a, ~a};
  endfunction

  // burst memory with a random gap of 0 to 3 cycles before each beat
  always @(negedge clk) begin
    rdDataValid = 1'b0;
    rdLast      = 1'b0;
    if (cacheRdValid) begin
      if (!inRead) begin
        inRead    = 1'b1;
        readAddr  = memAddr;
        lineReads = lineReads + 1;
      end
      assert (memAddr == {readAddr[`ADDR_W-1:`OFFSET_W], `OFFSET_W'(0)}) else
        failRun($sformatf("FAIL memAddr_o: got %h expected %h", memAddr,
                          {readAddr[`ADDR_W-1:`OFFSET_W], `OFFSET_W'(0)}));
      if (gapLeft > 0) begin
        gapLeft = gapLeft - 1;
      end else begin
        rdDataValid = 1'b1;
        memData     = memWord(readAddr + `ADDR_W'(beatNo * 8));
        rdLast      = (beatNo == `BEATS - 1);
        beatNo      = rdLast ? 0 : beatNo + 1;
        inRead      = !rdLast;
        gapLeft     = $unsigned($random(gapSeed)) % 4;
      end
    end
  end

  // responses checked in request order
  always @(negedge clk) begin
    pending_t p;
    if (rst_n && dataOk) begin
      assert (pendQ.size() > 0) else failRun("dataOk_o pulsed with no request outstanding");
      p = pendQ.pop_front();
      assert (rdData == memWord({p.addr[`ADDR_W-1:3], 3'b000})) else
        failRun($sformatf("FAIL rdData_o: got %h expected %h", rdData,
                          memWord({p.addr[`ADDR_W-1:3], 3'b000})));
      if (p.hit) begin
        assert (edgeCnt == p.accEdge + 1) else
          failRun($sformatf("hit at address %h was not answered two edges after it was taken",
                            p.addr));
      end else begin
        assert (edgeCnt > p.accEdge + 1) else
          failRun($sformatf("predicted miss at address %h came back with hit latency", p.addr));
      end
    end
  end

  `include "cacheTbTasks.svh"

  initial begin
    rst_n = 1'b0;
    valid = 1'b0;
    addr  = '0;
    flush = 1'b0;
    seed  = 32'h2745_e85f;
    clearModel(1'b1);
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    resetState();
    coldMissRead();
    sameLineHits();
    setEviction();
    flushInvalidates();
    randomReads();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* hw/cacheTop.sv */
`include "cache_macros.svh"

module cacheTop (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               valid_i,
  input  logic [`ADDR_W-1:0] addr_i,
  input  logic               flush_i,
  output logic               addrOk_o,
  output logic               dataOk_o,
  output logic [`XLEN-1:0]   rdData_o,
  output logic               cacheRdValid_o,
  output logic [`ADDR_W-1:0] memAddr_o,
  input  logic               rdDataValid_i,
  input  logic               rdLast_i,
  input  logic [`XLEN-1:0]   rdData_i
);

  cachePkg::tagEntry_t     tagRd0, tagRd1, tagWr;
  cachePkg::line_t         lineRd0, lineRd1, lineWr;
  cachePkg::refillResult_t refillRes;

  logic                ramEn, ramWe0, ramWe1;
  logic [`INDEX_W-1:0] ramIdx;
  logic                refillStart, refillDone;
  logic [`TAG_W-1:0]   missTag;
  logic [`INDEX_W-1:0] missIdx;
  logic                victimWay;

  cacheCtrl uCtrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_i       (valid_i),
    .addr_i        (addr_i),
    .flush_i       (flush_i),
    .tagRd0_i      (tagRd0),
    .tagRd1_i      (tagRd1),
    .lineRd0_i     (lineRd0),
    .lineRd1_i     (lineRd1),
    .refillDone_i  (refillDone),
    .refillRes_i   (refillRes),
    .addrOk_o      (addrOk_o),
    .dataOk_o      (dataOk_o),
    .rdData_o      (rdData_o),
    .ramEn_o       (ramEn),
    .ramWe0_o      (ramWe0),
    .ramWe1_o      (ramWe1),
    .ramIdx_o      (ramIdx),
    .tagWr_o       (tagWr),
    .lineWr_o      (lineWr),
    .refillStart_o (refillStart),
    .missTag_o     (missTag),
    .missIdx_o     (missIdx),
    .victimWay_o   (victimWay)
  );

  cacheRefill uRefill (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (refillStart),
    .tag_i          (missTag),
    .idx_i          (missIdx),
    .way_i          (victimWay),
    .rdDataValid_i  (rdDataValid_i),
    .rdLast_i       (rdLast_i),
    .rdData_i       (rdData_i),
    .cacheRdValid_o (cacheRdValid_o),
    .memAddr_o      (memAddr_o),
    .done_o         (refillDone),
    .result_o       (refillRes)
  );

  // tag and data RAMs share enable and index, each way has its own write
  cacheWayRam #(.ENTRY_T(cachePkg::tagEntry_t), .DEPTH(`SETS)) uTagRam0 (
    .clk(clk), .en_i(ramEn), .we_i(ramWe0), .addr_i(ramIdx),
    .wrEntry_i(tagWr), .rdEntry_o(tagRd0)
  );

  cacheWayRam #(.ENTRY_T(cachePkg::tagEntry_t), .DEPTH(`SETS)) uTagRam1 (
    .clk(clk), .en_i(ramEn), .we_i(ramWe1), .addr_i(ramIdx),
    .wrEntry_i(tagWr), .rdEntry_o(tagRd1)
  );

  cacheWayRam #(.ENTRY_T(cachePkg::line_t), .DEPTH(`SETS)) uDataRam0 (
    .clk(clk), .en_i(ramEn), .we_i(ramWe0), .addr_i(ramIdx),
    .wrEntry_i(lineWr), .rdEntry_o(lineRd0)
  );

  cacheWayRam #(.ENTRY_T(cachePkg::line_t), .DEPTH(`SETS)) uDataRam1 (
    .clk(clk), .en_i(ramEn), .we_i(ramWe1), .addr_i(ramIdx),
    .wrEntry_i(lineWr), .rdEntry_o(lineRd1)
  );

endmodule

/* hw/cacheRefill.sv */
`include "cache_macros.svh"

module cacheRefill (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start_i,
  input  logic [`TAG_W-1:0]       tag_i,
  input  logic [`INDEX_W-1:0]     idx_i,
  input  logic                    way_i,
  input  logic                    rdDataValid_i,
  input  logic                    rdLast_i,
  input  logic [`XLEN-1:0]        rdData_i,
  output logic                    cacheRdValid_o,
  output logic [`ADDR_W-1:0]      memAddr_o,
  output logic                    done_o,
  output cachePkg::refillResult_t result_o
);

  localparam int BEAT_W = $clog2(`BEATS);

  logic [BEAT_W-1:0]       beatCnt;
  logic                    beatTake;
  cachePkg::refillResult_t fillQ;

  assign beatTake = cacheRdValid_o && rdDataValid_i;

  // read level and beat counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cacheRdValid_o <= 1'b0;
      beatCnt        <= '0;
      done_o         <= 1'b0;
    end else begin
      done_o <= beatTake && rdLast_i;
      if (start_i) begin
        cacheRdValid_o <= 1'b1;
        beatCnt        <= '0;
      end else if (beatTake) begin
        beatCnt <= beatCnt + 1'b1;
        if (rdLast_i) begin
          cacheRdValid_o <= 1'b0;
        end
      end
    end
  end

  // fill target and line buffer
  // held after done until the next start
  always_ff @(posedge clk) begin
    if (start_i) begin
      fillQ.way <= way_i;
      fillQ.idx <= idx_i;
      fillQ.tag <= tag_i;
    end else if (beatTake) begin
      fillQ.line[beatCnt] <= rdData_i;
    end
  end

  assign result_o  = fillQ;
  assign memAddr_o = {fillQ.tag, fillQ.idx, {`OFFSET_W{1'b0}}};

  aBeatInRead: assert property (@(posedge clk) disable iff (!rst_n)
    rdDataValid_i |-> cacheRdValid_o);

  // last flag on the fourth beat and nowhere else
  aLastOnFourth: assert property (@(posedge clk) disable iff (!rst_n)
    beatTake |-> (rdLast_i == (beatCnt == BEAT_W'(`BEATS - 1))));

  aLastWithData: assert property (@(posedge clk) disable iff (!rst_n)
    rdLast_i |-> rdDataValid_i);

endmodule

/* hw/cacheCtrl.sv */
`include "cache_macros.svh"

module cacheCtrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    valid_i,
  input  logic [`ADDR_W-1:0]      addr_i,
  input  logic                    flush_i,
  input  cachePkg::tagEntry_t     tagRd0_i,
  input  cachePkg::tagEntry_t     tagRd1_i,
  input  cachePkg::line_t         lineRd0_i,
  input  cachePkg::line_t         lineRd1_i,
  input  logic                    refillDone_i,
  input  cachePkg::refillResult_t refillRes_i,
  output logic                    addrOk_o,
  output logic                    dataOk_o,
  output logic [`XLEN-1:0]        rdData_o,
  output logic                    ramEn_o,
  output logic                    ramWe0_o,
  output logic                    ramWe1_o,
  output logic [`INDEX_W-1:0]     ramIdx_o,
  output cachePkg::tagEntry_t     tagWr_o,
  output cachePkg::line_t         lineWr_o,
  output logic                    refillStart_o,
  output logic [`TAG_W-1:0]       missTag_o,
  output logic [`INDEX_W-1:0]     missIdx_o,
  output logic                    victimWay_o
);

  localparam int WORD_OFF = $clog2(`XLEN / 8);

  cachePkg::ctrlState_t state, stateNext;

  logic [`ADDR_W-1:0]  reqAddr;
  logic [`TAG_W-1:0]   reqTag;
  logic [`INDEX_W-1:0] reqIdx;
  logic [`OFFSET_W-WORD_OFF-1:0] reqWord;

  logic [`SETS-1:0] way0Valid;
  logic [`SETS-1:0] way1Valid;
  logic [`SETS-1:0] lruBits;

  logic way0Hit, way1Hit, cacheHit;
  logic accept;
  logic [1:0] pendCnt;
  cachePkg::line_t lineSel;

  assign reqTag  = reqAddr[`ADDR_W-1 -: `TAG_W];
  assign reqIdx  = reqAddr[`OFFSET_W +: `INDEX_W];
  assign reqWord = reqAddr[`OFFSET_W-1:WORD_OFF];

  // tag RAM output belongs to the latched request during compare
  assign way0Hit  = way0Valid[reqIdx] && (tagRd0_i.tag == reqTag);
  assign way1Hit  = way1Valid[reqIdx] && (tagRd1_i.tag == reqTag);
  assign cacheHit = way0Hit || way1Hit;

  assign addrOk_o = (state == cachePkg::IDLE) || ((state == cachePkg::COMPARE) && cacheHit);
  assign accept   = valid_i && addrOk_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= cachePkg::IDLE;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      cachePkg::IDLE: begin
        if (valid_i) begin
          stateNext = cachePkg::COMPARE;
        end
      end
      cachePkg::COMPARE: begin
        if (!cacheHit) begin
          stateNext = cachePkg::MISS_WAIT;
        end else if (!valid_i) begin
          stateNext = cachePkg::IDLE;
        end
      end
      cachePkg::MISS_WAIT: begin
        if (refillDone_i) begin
          stateNext = cachePkg::WRITE;
        end
      end
      cachePkg::WRITE:  stateNext = cachePkg::REPLAY;
      cachePkg::REPLAY: stateNext = cachePkg::COMPARE;
      default:          stateNext = cachePkg::IDLE;
    endcase
  end

  // request latch, the replay reads it again
  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= addr_i;
    end
  end

  // RAM port: fill write, replay read or new lookup
  // refill engine holds its result after done, so it is still good in WRITE
  always_comb begin
    ramEn_o  = accept;
    ramIdx_o = addr_i[`OFFSET_W +: `INDEX_W];
    if (state == cachePkg::WRITE) begin
      ramEn_o  = 1'b1;
      ramIdx_o = refillRes_i.idx;
    end else if (state == cachePkg::REPLAY) begin
      ramEn_o  = 1'b1;
      ramIdx_o = reqIdx;
    end
  end

  assign ramWe0_o      = (state == cachePkg::WRITE) && !refillRes_i.way;
  assign ramWe1_o      = (state == cachePkg::WRITE) && refillRes_i.way;
  assign tagWr_o.valid = 1'b1;
  assign tagWr_o.tag   = refillRes_i.tag;
  assign lineWr_o      = refillRes_i.line;

  // miss request, invalid way first, otherwise the LRU way
  assign refillStart_o = (state == cachePkg::COMPARE) && !cacheHit;
  assign missTag_o     = reqTag;
  assign missIdx_o     = reqIdx;
  assign victimWay_o   = !way0Valid[reqIdx] ? 1'b0 :
                         !way1Valid[reqIdx] ? 1'b1 : lruBits[reqIdx];

  // lru bit names the way not used last
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      way0Valid <= '0;
      way1Valid <= '0;
      lruBits   <= '0;
    end else begin
      if ((state == cachePkg::IDLE) && !valid_i && flush_i) begin
        way0Valid <= '0;
        way1Valid <= '0;
      end else if (state == cachePkg::WRITE) begin
        if (refillRes_i.way) begin
          way1Valid[refillRes_i.idx] <= 1'b1;
        end else begin
          way0Valid[refillRes_i.idx] <= 1'b1;
        end
        lruBits[refillRes_i.idx] <= ~refillRes_i.way;
      end else if ((state == cachePkg::COMPARE) && cacheHit) begin
        lruBits[reqIdx] <= way0Hit;
      end
    end
  end

  // word select
  assign lineSel = way1Hit ? lineRd1_i : lineRd0_i;

  always_ff @(posedge clk) begin
    if ((state == cachePkg::COMPARE) && cacheHit) begin
      rdData_o <= lineSel[reqWord];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dataOk_o <= 1'b0;
    end else begin
      dataOk_o <= (state == cachePkg::COMPARE) && cacheHit;
    end
  end

  // requests taken but not yet answered
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pendCnt <= '0;
    end else if (accept && !dataOk_o) begin
      pendCnt <= pendCnt + 2'd1;
    end else if (!accept && dataOk_o) begin
      pendCnt <= pendCnt - 2'd1;
    end
  end

  aDataOkPending: assert property (@(posedge clk) disable iff (!rst_n)
    (dataOk_o && (state == cachePkg::IDLE)) |-> (pendCnt != 2'd0));

  aOneWayHit: assert property (@(posedge clk) disable iff (!rst_n)
    (state == cachePkg::COMPARE) |-> !(way0Hit && way1Hit));

endmodule

/* hw/cacheWayRam.sv */
module cacheWayRam #(
  parameter type ENTRY_T = logic [7:0],
  parameter int  DEPTH   = 64
) (
  input  logic                     clk,
  input  logic                     en_i,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] addr_i,
  input  ENTRY_T                   wrEntry_i,
  output ENTRY_T                   rdEntry_o
);

  ENTRY_T mem [DEPTH];

  // read-first: a write cycle returns the old contents
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wrEntry_i;
      end
      rdEntry_o <= mem[addr_i];
    end
  end

endmodule

/* hw/cachePkg.sv */
`include "cache_macros.svh"

package cachePkg;

  // one tag RAM word
  // valid is written as 1, the controller masks it with its own array
  typedef struct packed {
    logic             valid;
    logic [`TAG_W-1:0] tag;
  } tagEntry_t;

  // one data RAM word, beat 0 in the low word
  typedef logic [`BEATS-1:0][`XLEN-1:0] line_t;

  // one completed fill from memory
  typedef struct packed {
    logic               way;
    logic [`INDEX_W-1:0] idx;
    logic [`TAG_W-1:0]   tag;
    line_t              line;
  } refillResult_t;

  // lookup controller states
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    COMPARE   = 3'd1,
    MISS_WAIT = 3'd2,
    WRITE     = 3'd3,
    REPLAY    = 3'd4
  } ctrlState_t;

endpackage

/* hw/cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// core address and data word
`define ADDR_W 32
`define XLEN 64

// address split: tag | index | offset
`define OFFSET_W 5
`define INDEX_W 6
`define TAG_W 21

// number of sets per way
`define SETS 64

// 64-bit words per 32-byte line
`define BEATS 4

`endif
